// File: hdl/udp_rx_defines.svh
`ifndef UDP_RX_DEFINES_SVH
`define UDP_RX_DEFINES_SVH

// stream geometry
`define UDP_RX_DATA_W        64
`define UDP_RX_KEEP_W        8

// header beats, counted from the first beat of a frame
`define UDP_RX_BEAT_ETH      0       // dst mac, src mac high half
`define UDP_RX_BEAT_ETH_IP   1       // src mac low half, version/ihl
`define UDP_RX_BEAT_IP       2       // length, id, fragment, ttl, protocol
`define UDP_RX_BEAT_IP_ADDR  3       // header checksum, src ip, dst ip high
`define UDP_RX_BEAT_UDP      4       // dst ip low, udp ports, udp length
`define UDP_RX_PAYLOAD_BEAT  5       // payload begins at byte 2 of this beat

// buffer depths
`define UDP_RX_FRAME_DEPTH   512     // beats
`define UDP_RX_HDR_DEPTH     16      // frames

`endif

// File: hdl/net_hdr_pkg.sv
`default_nettype none

package net_hdr_pkg;

   // protocol fields, held in network order (first byte on the wire is the msb)
   typedef logic [47:0] mac_addr_t;
   typedef logic [31:0] ip_addr_t;
   typedef logic [15:0] udp_port_t;
   typedef logic [15:0] csum_t;         // ones' complement word

   // per frame sender details, 112 bits
   typedef struct packed {
      mac_addr_t src_mac;
      ip_addr_t  src_ip;
      udp_port_t src_udp;
      udp_port_t dst_udp;
   } sender_info_t;

endpackage

`default_nettype wire

// File: hdl/stream_pkg.sv
`default_nettype none

`include "udp_rx_defines.svh"

package stream_pkg;

   typedef logic [`UDP_RX_DATA_W-1:0] beat_data_t;
   typedef logic [`UDP_RX_KEEP_W-1:0] beat_keep_t;
   typedef logic [7:0] beat_index_t;                           // saturating
   typedef logic [$clog2(`UDP_RX_FRAME_DEPTH):0] frame_ptr_t;  // msb is wrap bit

endpackage

`default_nettype wire

// File: hdl/ip_checksum.sv
`timescale 1ns/1ps
`default_nettype none

module ip_checksum (
   input  wire                         clk,
   input  wire                         reset,
   input  wire                         start,
   input  wire stream_pkg::beat_data_t halfwords,
   input  wire [3:0]                   lane_en,
   input  wire                         add,
   output logic                        csum_ok
);

   net_hdr_pkg::csum_t sum;
   net_hdr_pkg::csum_t folded;
   logic [18:0]        total;                 // running sum plus four lanes
   logic [16:0]        fold1;

   // byte swapped lanes still fold to all ones on a good header
   always_comb begin
      total = {3'b000, sum};
      for (int i = 0; i < 4; i++) begin
         if (lane_en[i])
            total = total + {3'b000, halfwords[16*i +: 16]};
      end
      fold1  = {1'b0, total[15:0]} + {14'b0, total[18:16]};
      folded = fold1[15:0] + {15'b0, fold1[16]};   // end-around carry
   end

   always_ff @(posedge clk) begin
      if (reset || start)
         sum <= '0;
      else if (add)
         sum <= folded;
   end

   assign csum_ok = (sum == 16'hffff);

   // the parser starts a header on beat 0 and adds only on later beats
   a_no_add_on_start: assert property (@(posedge clk) disable iff (reset) !(start && add));

endmodule

`default_nettype wire

// File: hdl/header_parser.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_defines.svh"

module header_parser (
   input  wire                           clk,
   input  wire                           reset,
   input  wire stream_pkg::beat_data_t   rx_tdata,
   input  wire                           rx_tvalid,
   input  wire                           rx_tlast,
   input  wire net_hdr_pkg::mac_addr_t   cfg_mac,
   input  wire net_hdr_pkg::ip_addr_t    cfg_ip,
   output logic                          hdr_ok,
   output net_hdr_pkg::sender_info_t     sender_info
);

   stream_pkg::beat_index_t beat_cnt;
   net_hdr_pkg::mac_addr_t  dst_mac;
   net_hdr_pkg::mac_addr_t  src_mac;
   net_hdr_pkg::ip_addr_t   src_ip;
   net_hdr_pkg::ip_addr_t   dst_ip;
   net_hdr_pkg::udp_port_t  src_udp;
   net_hdr_pkg::udp_port_t  dst_udp;
   logic [3:0]              lane_en;
   logic                    csum_start;
   logic                    csum_add;
   logic                    csum_ok;

   // lane bytes to field value, byte 0 is the msb on the wire
   function automatic logic [15:0] swap16(input logic [15:0] hw);
      return {hw[7:0], hw[15:8]};
   endfunction

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_cnt <= '0;
      end else if (rx_tvalid) begin
         if (rx_tlast)
            beat_cnt <= '0;
         else if (beat_cnt != '1)
            beat_cnt <= beat_cnt + 1'b1;        // holds at 255 on jumbo frames
      end
   end

   // ******************************************************************
   // field capture from fixed beat and lane positions
   // ******************************************************************
   always_ff @(posedge clk) begin
      if (rx_tvalid) begin
         case (beat_cnt)
            `UDP_RX_BEAT_ETH: begin
               dst_mac <= {swap16(rx_tdata[15:0]), swap16(rx_tdata[31:16]),
                           swap16(rx_tdata[47:32])};
               src_mac[47:32] <= swap16(rx_tdata[63:48]);
            end
            `UDP_RX_BEAT_ETH_IP: begin
               src_mac[31:0] <= {swap16(rx_tdata[15:0]), swap16(rx_tdata[31:16])};
            end
            `UDP_RX_BEAT_IP_ADDR: begin
               src_ip <= {swap16(rx_tdata[31:16]), swap16(rx_tdata[47:32])};
               dst_ip[31:16] <= swap16(rx_tdata[63:48]);
            end
            `UDP_RX_BEAT_UDP: begin
               dst_ip[15:0] <= swap16(rx_tdata[15:0]);
               src_udp <= swap16(rx_tdata[31:16]);
               dst_udp <= swap16(rx_tdata[47:32]);
            end
            default: ;
         endcase
      end
   end

   // ip header halfwords, bytes 14 to 33 of the frame
   always_comb begin
      case (beat_cnt)
         `UDP_RX_BEAT_ETH_IP:                  lane_en = 4'b1000;
         `UDP_RX_BEAT_IP, `UDP_RX_BEAT_IP_ADDR: lane_en = 4'b1111;
         `UDP_RX_BEAT_UDP:                     lane_en = 4'b0001;
         default:                              lane_en = 4'b0000;
      endcase
   end

   assign csum_start = rx_tvalid && (beat_cnt == `UDP_RX_BEAT_ETH);
   assign csum_add   = rx_tvalid && (lane_en != 4'b0000);

   ip_checksum ip_checksum0 (
      .clk       (clk),
      .reset     (reset),
      .start     (csum_start),
      .halfwords (rx_tdata),
      .lane_en   (lane_en),
      .add       (csum_add),
      .csum_ok   (csum_ok)
   );

   // verdict and sender details, held until the next last beat
   always_ff @(posedge clk) begin
      if (reset)
         hdr_ok <= 1'b0;
      else if (rx_tvalid && rx_tlast)
         hdr_ok <= (dst_mac == cfg_mac) && (dst_ip == cfg_ip) && csum_ok &&
                   (beat_cnt >= `UDP_RX_PAYLOAD_BEAT);
   end

   always_ff @(posedge clk) begin
      if (rx_tvalid && rx_tlast) begin
         sender_info.src_mac <= src_mac;
         sender_info.src_ip  <= src_ip;
         sender_info.src_udp <= src_udp;
         sender_info.dst_udp <= dst_udp;
      end
   end

endmodule

`default_nettype wire

// File: hdl/payload_aligner.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_defines.svh"

module payload_aligner (
   input  wire                         clk,
   input  wire                         reset,
   input  wire stream_pkg::beat_data_t rx_tdata,
   input  wire stream_pkg::beat_keep_t rx_tkeep,
   input  wire                         rx_tvalid,
   input  wire                         rx_tlast,
   input  wire                         rx_tuser,
   output stream_pkg::beat_data_t      pay_tdata,
   output stream_pkg::beat_keep_t      pay_tkeep,
   output logic                        pay_tvalid,
   output logic                        pay_tlast,
   output logic                        pay_tuser
);

   stream_pkg::beat_index_t          beat_cnt;
   logic [`UDP_RX_DATA_W-17:0]       prev_data;    // upper six bytes of last beat
   logic [`UDP_RX_KEEP_W-3:0]        prev_keep;
   logic                             user_seen;
   logic                             user_any;
   logic                             join_beat;
   logic                             extra;
   logic                             carry_pending;
   logic                             carry_user;

   assign user_any  = user_seen | rx_tuser;
   assign join_beat = rx_tvalid && (beat_cnt > `UDP_RX_PAYLOAD_BEAT);
   // more than two bytes left in the last beat, so one more beat follows
   assign extra = rx_tvalid && rx_tlast && rx_tkeep[2] && (beat_cnt >= `UDP_RX_PAYLOAD_BEAT);

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_cnt      <= '0;
         user_seen     <= 1'b0;
         carry_pending <= 1'b0;
         pay_tvalid    <= 1'b0;
      end else begin
         if (rx_tvalid) begin
            if (rx_tlast)
               beat_cnt <= '0;
            else if (beat_cnt != '1)
               beat_cnt <= beat_cnt + 1'b1;
            user_seen <= rx_tlast ? 1'b0 : user_any;
         end
         carry_pending <= extra;
         pay_tvalid    <= join_beat || carry_pending;
      end
   end

   // ******************************************************************
   // two byte shift, one output register
   // ******************************************************************
   always_ff @(posedge clk) begin
      if (rx_tvalid) begin
         prev_data <= rx_tdata[`UDP_RX_DATA_W-1:16];
         prev_keep <= rx_tkeep[`UDP_RX_KEEP_W-1:2];
      end
      if (extra)
         carry_user <= user_any;
      if (carry_pending) begin                    // trailing beat
         pay_tdata <= {16'h0000, prev_data};
         pay_tkeep <= {2'b00, prev_keep};
         pay_tlast <= 1'b1;
         pay_tuser <= carry_user;
      end else if (join_beat) begin
         pay_tdata <= {rx_tdata[15:0], prev_data};
         pay_tkeep <= {rx_tkeep[1:0], prev_keep};
         pay_tlast <= rx_tlast && !rx_tkeep[2];
         pay_tuser <= user_any;
      end
   end

endmodule

`default_nettype wire

// File: hdl/frame_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_defines.svh"

module frame_fifo (
   input  wire                         clk,
   input  wire                         reset,
   input  wire stream_pkg::beat_data_t pay_tdata,
   input  wire stream_pkg::beat_keep_t pay_tkeep,
   input  wire                         pay_tvalid,
   input  wire                         pay_tlast,
   input  wire                         pay_tuser,
   input  wire                         hdr_ok,
   input  wire                         hdr_full,
   input  wire                         tx_tready,
   output stream_pkg::beat_data_t      tx_tdata,
   output stream_pkg::beat_keep_t      tx_tkeep,
   output logic                        tx_tvalid,
   output logic                        tx_tlast,
   output logic                        commit
);

   localparam int depth = `UDP_RX_FRAME_DEPTH;
   localparam int aw    = $clog2(depth);

   stream_pkg::beat_data_t mem_data [depth];
   stream_pkg::beat_keep_t mem_keep [depth];
   logic                   mem_last [depth];
   stream_pkg::frame_ptr_t wr_ptr;
   stream_pkg::frame_ptr_t commit_ptr;          // end of the last whole frame
   stream_pkg::frame_ptr_t rd_ptr;
   stream_pkg::frame_ptr_t backlog;
   logic                   full;
   logic                   wr_ok;
   logic                   overflow;            // a beat of this frame was lost
   logic                   user_seen;
   logic                   rd_en;

   assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
   assign wr_ok = pay_tvalid && !full && !overflow;
   assign commit = pay_tvalid && pay_tlast && wr_ok && hdr_ok && !hdr_full &&
                   !user_seen && !pay_tuser;

   // ******************************************************************
   // write side, commit or rewind at frame end
   // ******************************************************************
   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem_data[wr_ptr[aw-1:0]] <= pay_tdata;
         mem_keep[wr_ptr[aw-1:0]] <= pay_tkeep;
         mem_last[wr_ptr[aw-1:0]] <= pay_tlast;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         commit_ptr <= '0;
         overflow   <= 1'b0;
         user_seen  <= 1'b0;
      end else if (pay_tvalid) begin
         if (pay_tlast) begin
            overflow  <= 1'b0;
            user_seen <= 1'b0;
            if (commit) begin
               wr_ptr     <= wr_ptr + 1'b1;
               commit_ptr <= wr_ptr + 1'b1;
            end else begin
               wr_ptr <= commit_ptr;               // drop the whole frame
            end
         end else begin
            overflow  <= overflow | full;
            user_seen <= user_seen | pay_tuser;
            if (wr_ok)
               wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   // read side, only committed beats, output register held under back-pressure
   assign rd_en = (rd_ptr != commit_ptr) && (!tx_tvalid || tx_tready);

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr    <= '0;
         tx_tvalid <= 1'b0;
      end else if (rd_en) begin
         rd_ptr    <= rd_ptr + 1'b1;
         tx_tvalid <= 1'b1;
      end else if (tx_tready) begin
         tx_tvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         tx_tdata <= mem_data[rd_ptr[aw-1:0]];
         tx_tkeep <= mem_keep[rd_ptr[aw-1:0]];
         tx_tlast <= mem_last[rd_ptr[aw-1:0]];
      end
   end

   assign backlog = commit_ptr - rd_ptr;

   // reader stays behind the last committed frame
   a_rd_behind_commit: assert property (@(posedge clk) disable iff (reset) backlog <= depth);

endmodule

`default_nettype wire

// File: hdl/fwft_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fwft_fifo #(
   parameter type item_t = logic [7:0],
   parameter int  depth  = 16
) (
   input  wire        clk,
   input  wire        reset,
   input  wire        wr,
   input  wire item_t din,
   input  wire        rd,
   output item_t      dout,
   output logic       full,
   output logic       empty
);

   localparam int aw = $clog2(depth);

   item_t       mem [depth];
   logic [aw:0] wr_ptr;
   logic [aw:0] rd_ptr;

   assign dout  = mem[rd_ptr[aw-1:0]];          // head visible without a read
   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);

   always_ff @(posedge clk) begin
      if (wr)
         mem[wr_ptr[aw-1:0]] <= din;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (rd)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // producer and consumer are expected to track the fill level themselves
   a_no_write_full: assert property (@(posedge clk) disable iff (reset) !(wr && full));
   a_no_read_empty: assert property (@(posedge clk) disable iff (reset) !(rd && empty));

endmodule

`default_nettype wire

// File: hdl/udp_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_rx_defines.svh"

module udp_rx_top (
   input  wire                         clk,
   input  wire                         reset,
   input  wire net_hdr_pkg::mac_addr_t cfg_mac,
   input  wire net_hdr_pkg::ip_addr_t  cfg_ip,
   input  wire stream_pkg::beat_data_t rx_tdata,
   input  wire stream_pkg::beat_keep_t rx_tkeep,
   input  wire                         rx_tvalid,
   input  wire                         rx_tlast,
   input  wire                         rx_tuser,
   output wire stream_pkg::beat_data_t tx_tdata,
   output wire stream_pkg::beat_keep_t tx_tkeep,
   output wire                         tx_tvalid,
   output wire                         tx_tlast,
   input  wire                         tx_tready,
   output wire net_hdr_pkg::mac_addr_t src_mac,
   output wire net_hdr_pkg::ip_addr_t  src_ip,
   output wire net_hdr_pkg::udp_port_t src_udp,
   output wire net_hdr_pkg::udp_port_t dst_udp
);

   wire                            hdr_ok;
   wire net_hdr_pkg::sender_info_t sender_info;
   wire net_hdr_pkg::sender_info_t hdr_dout;
   wire                            hdr_full;
   wire                            commit;
   wire stream_pkg::beat_data_t    pay_tdata;
   wire stream_pkg::beat_keep_t    pay_tkeep;
   wire                            pay_tvalid;
   wire                            pay_tlast;
   wire                            pay_tuser;

   header_parser header_parser0 (
      .clk         (clk),
      .reset       (reset),
      .rx_tdata    (rx_tdata),
      .rx_tvalid   (rx_tvalid),
      .rx_tlast    (rx_tlast),
      .cfg_mac     (cfg_mac),
      .cfg_ip      (cfg_ip),
      .hdr_ok      (hdr_ok),
      .sender_info (sender_info)
   );

   payload_aligner payload_aligner0 (
      .clk        (clk),
      .reset      (reset),
      .rx_tdata   (rx_tdata),
      .rx_tkeep   (rx_tkeep),
      .rx_tvalid  (rx_tvalid),
      .rx_tlast   (rx_tlast),
      .rx_tuser   (rx_tuser),
      .pay_tdata  (pay_tdata),
      .pay_tkeep  (pay_tkeep),
      .pay_tvalid (pay_tvalid),
      .pay_tlast  (pay_tlast),
      .pay_tuser  (pay_tuser)
   );

   frame_fifo frame_fifo0 (
      .clk        (clk),
      .reset      (reset),
      .pay_tdata  (pay_tdata),
      .pay_tkeep  (pay_tkeep),
      .pay_tvalid (pay_tvalid),
      .pay_tlast  (pay_tlast),
      .pay_tuser  (pay_tuser),
      .hdr_ok     (hdr_ok),
      .hdr_full   (hdr_full),
      .tx_tready  (tx_tready),
      .tx_tdata   (tx_tdata),
      .tx_tkeep   (tx_tkeep),
      .tx_tvalid  (tx_tvalid),
      .tx_tlast   (tx_tlast),
      .commit     (commit)
   );

   // sender details, popped when the last beat of a frame leaves
   fwft_fifo #(
      .item_t (net_hdr_pkg::sender_info_t),
      .depth  (`UDP_RX_HDR_DEPTH)
   ) hdr_fifo0 (
      .clk   (clk),
      .reset (reset),
      .wr    (commit),
      .din   (sender_info),
      .rd    (tx_tvalid && tx_tready && tx_tlast),
      .dout  (hdr_dout),
      .full  (hdr_full),
      .empty ()
   );

   assign src_mac = hdr_dout.src_mac;
   assign src_ip  = hdr_dout.src_ip;
   assign src_udp = hdr_dout.src_udp;
   assign dst_udp = hdr_dout.dst_udp;

endmodule

`default_nettype wire

// File: test/udp_rx_frames.svh
`ifndef UDP_RX_FRAMES_SVH
`define UDP_RX_FRAMES_SVH

// ***********************************************************************
// random source and frame builder
// ***********************************************************************
function automatic logic [31:0] xorshift32(input logic [31:0] x);
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   return x;
endfunction

function automatic logic [31:0] rand32();
   rng = xorshift32(rng);
   return rng;
endfunction

// lowest count bytes of value, msb first as on the wire
task automatic push_bytes(input logic [63:0] value, input int count);
   int i;
   for (i = count - 1; i >= 0; i--)
      frame_bytes.push_back(value[8*i +: 8]);
endtask

// ones' complement sum over the 20 byte ip header
function automatic logic [15:0] header_sum();
   logic [31:0] sum;
   int          i;
   sum = '0;
   for (i = 14; i < 34; i += 2)
      sum = sum + {16'h0000, frame_bytes[i], frame_bytes[i+1]};
   sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};
   sum = {16'h0000, sum[15:0]} + {16'h0000, sum[31:16]};   // second carry fold
   return sum[15:0];
endfunction

task automatic build_frame(input net_hdr_pkg::mac_addr_t dmac, input net_hdr_pkg::ip_addr_t dip,
                           input int pay_len);
   logic [31:0] r;
   logic [15:0] csum;
   int          i;
   frame_bytes.delete();
   push_bytes(64'(dmac), 6);
   push_bytes({rand32(), rand32()}, 6);      // src mac
   push_bytes(64'h0800, 2);                  // ethertype ipv4
   push_bytes(64'h4500, 2);
   push_bytes(64'(28 + pay_len), 2);         // ip total length
   push_bytes(64'(rand32()), 2);             // identification
   push_bytes(64'h4000_4011, 4);             // dont fragment, ttl 64, udp
   push_bytes(64'h0, 2);                     // checksum, filled below
   push_bytes(64'(rand32()), 4);             // src ip
   push_bytes(64'(dip), 4);
   push_bytes(64'(rand32()), 4);             // src and dst port
   push_bytes(64'(8 + pay_len), 2);
   push_bytes(64'h0, 2);                     // udp checksum unused
   for (i = 0; i < pay_len; i++) begin
      r = rand32();
      frame_bytes.push_back(r[7:0]);
   end
   csum = ~header_sum();
   frame_bytes[24] = csum[15:8];
   frame_bytes[25] = csum[7:0];
endtask

// ***********************************************************************
// reference model and compare tasks
// ***********************************************************************
function automatic bit expected_frame(input bit user_err,
                                      output net_hdr_pkg::sender_info_t info);
   net_hdr_pkg::mac_addr_t dmac;
   net_hdr_pkg::ip_addr_t  dip;
   int                     i;
   dmac = '0;
   dip  = '0;
   info = '0;
   for (i = 0; i < 6; i++) begin
      dmac         = {dmac[39:0], frame_bytes[i]};
      info.src_mac = {info.src_mac[39:0], frame_bytes[6+i]};
   end
   for (i = 0; i < 4; i++) begin
      info.src_ip = {info.src_ip[23:0], frame_bytes[26+i]};
      dip         = {dip[23:0], frame_bytes[30+i]};
   end
   info.src_udp = {frame_bytes[34], frame_bytes[35]};
   info.dst_udp = {frame_bytes[36], frame_bytes[37]};
   exp_payload.delete();
   for (i = 42; i < frame_bytes.size(); i++)
      exp_payload.push_back(frame_bytes[i]);    // udp payload
   return (dmac == cfg_mac) && (dip == cfg_ip) && (header_sum() == 16'hffff) && !user_err;
endfunction

task automatic compare_data(input string name, input stream_pkg::beat_data_t got,
                            input stream_pkg::beat_data_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic compare_keep(input string name, input stream_pkg::beat_keep_t got,
                            input stream_pkg::beat_keep_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic compare_info(input string name, input net_hdr_pkg::sender_info_t got,
                            input net_hdr_pkg::sender_info_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

`endif

// File: test/tb_udp_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_udp_rx;

   localparam int                     period   = 100;
   localparam net_hdr_pkg::mac_addr_t my_mac   = 48'h02005e102030;
   localparam net_hdr_pkg::ip_addr_t  my_ip    = 32'hc0a80110;
   localparam int                     good     = 0;
   localparam int                     bad_mac  = 1;
   localparam int                     bad_ip   = 2;
   localparam int                     bad_csum = 3;
   localparam int                     bad_user = 4;

   logic                   clk;
   logic                   reset;
   net_hdr_pkg::mac_addr_t cfg_mac;
   net_hdr_pkg::ip_addr_t  cfg_ip;
   stream_pkg::beat_data_t rx_tdata;
   stream_pkg::beat_keep_t rx_tkeep;
   logic                   rx_tvalid;
   logic                   rx_tlast;
   logic                   rx_tuser;
   stream_pkg::beat_data_t tx_tdata;
   stream_pkg::beat_keep_t tx_tkeep;
   logic                   tx_tvalid;
   logic                   tx_tlast;
   logic                   tx_tready;
   net_hdr_pkg::mac_addr_t src_mac;
   net_hdr_pkg::ip_addr_t  src_ip;
   net_hdr_pkg::udp_port_t src_udp;
   net_hdr_pkg::udp_port_t dst_udp;

   logic [31:0]                rng = 32'habe0d6c6;
   logic [31:0]                ready_rng;
   bit                         random_ready;
   logic [7:0]                 frame_bytes [$];
   logic [7:0]                 exp_payload [$];
   stream_pkg::beat_data_t     exp_data [$];
   stream_pkg::beat_keep_t     exp_keep [$];
   logic                       exp_last [$];
   net_hdr_pkg::sender_info_t  exp_info [$];    // one per delivered frame
   int                         errors = 0;
   int                         checks = 0;
   int                         tests = 0;
   int                         tests_failed = 0;
   int                         test_start_errors;
   string                      test_name;

   `include "udp_rx_frames.svh"

   udp_rx_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .cfg_mac   (cfg_mac),
      .cfg_ip    (cfg_ip),
      .rx_tdata  (rx_tdata),
      .rx_tkeep  (rx_tkeep),
      .rx_tvalid (rx_tvalid),
      .rx_tlast  (rx_tlast),
      .rx_tuser  (rx_tuser),
      .tx_tdata  (tx_tdata),
      .tx_tkeep  (tx_tkeep),
      .tx_tvalid (tx_tvalid),
      .tx_tlast  (tx_tlast),
      .tx_tready (tx_tready),
      .src_mac   (src_mac),
      .src_ip    (src_ip),
      .src_udp   (src_udp),
      .dst_udp   (dst_udp)
   );

   initial begin
      clk = 1'b0;
      forever #(period / 2) clk = ~clk;
   end

   initial begin
      tx_tready = 1'b1;
      forever begin
         @(posedge clk);
         #10;
         ready_rng = xorshift32(ready_rng);
         tx_tready = random_ready ? ready_rng[0] : 1'b1;   // half rate when random
      end
   end

   function automatic stream_pkg::beat_data_t keep_mask(input stream_pkg::beat_keep_t keep);
      stream_pkg::beat_data_t m;
      int                     k;
      m = '0;
      for (k = 0; k < 8; k++)
         if (keep[k])
            m[8*k +: 8] = 8'hff;
      return m;
   endfunction

   // ********************************************************************
   // checker samples mid cycle where outputs are settled
   // ********************************************************************
   always @(negedge clk) begin
      if (!reset && tx_tvalid && tx_tready) begin
         if (exp_data.size() == 0 || exp_info.size() == 0) begin
            errors++;
            $display("unexpected beat on the output while no frame was expected");
         end else begin
            compare_data("tx_tdata", tx_tdata & keep_mask(exp_keep[0]), exp_data[0]);
            compare_keep("tx_tkeep", tx_tkeep, exp_keep[0]);
            compare_flag("tx_tlast", tx_tlast, exp_last[0]);
            compare_info("sender_info", {src_mac, src_ip, src_udp, dst_udp}, exp_info[0]);
            if (exp_last[0])
               void'(exp_info.pop_front());
            void'(exp_data.pop_front());
            void'(exp_keep.pop_front());
            void'(exp_last.pop_front());
         end
      end
   end

   task automatic next_cycle();
      @(posedge clk);
      #10;
   endtask

   task automatic send_frame(input bit user_last);
      int nbeats;
      int b;
      int k;
      nbeats = (frame_bytes.size() + 7) / 8;
      for (b = 0; b < nbeats; b++) begin
         rx_tdata = '0;
         rx_tkeep = '0;
         for (k = 0; k < 8; k++) begin
            if (8 * b + k < frame_bytes.size()) begin
               rx_tdata[8*k +: 8] = frame_bytes[8*b+k];
               rx_tkeep[k]        = 1'b1;
            end
         end
         rx_tvalid = 1'b1;
         rx_tlast  = (b == nbeats - 1);
         rx_tuser  = user_last && (b == nbeats - 1);
         next_cycle();
      end
      rx_tvalid = 1'b0;
      rx_tlast  = 1'b0;
      rx_tuser  = 1'b0;
      rx_tdata  = '0;
      rx_tkeep  = '0;
   endtask

   task automatic queue_expected(input net_hdr_pkg::sender_info_t info);
      stream_pkg::beat_data_t d;
      stream_pkg::beat_keep_t kp;
      int                     b;
      int                     k;
      for (b = 0; b * 8 < exp_payload.size(); b++) begin
         d  = '0;
         kp = '0;
         for (k = 0; k < 8; k++) begin
            if (8 * b + k < exp_payload.size()) begin
               d[8*k +: 8] = exp_payload[8*b+k];
               kp[k]       = 1'b1;
            end
         end
         exp_data.push_back(d);
         exp_keep.push_back(kp);
         exp_last.push_back((b + 1) * 8 >= exp_payload.size());
      end
      exp_info.push_back(info);
   endtask

   task automatic offer_frame(input int kind, input int pay_len);
      net_hdr_pkg::sender_info_t info;
      bit                        deliver;
      build_frame((kind == bad_mac) ? my_mac ^ 48'h1 : my_mac,
                  (kind == bad_ip) ? my_ip ^ 32'h100 : my_ip, pay_len);
      if (kind == bad_csum)
         frame_bytes[24] = frame_bytes[24] ^ 8'h08;    // one bit of the header checksum
      deliver = expected_frame(kind == bad_user, info);
      if (deliver)
         queue_expected(info);
      send_frame(kind == bad_user);
   endtask

   // drained and then quiet for 8 cycles so a leaked bad frame would show
   task automatic wait_idle(input int limit);
      int cycles;
      int quiet;
      cycles = 0;
      quiet  = 0;
      while ((exp_data.size() != 0 || quiet < 8) && cycles < limit) begin
         next_cycle();
         cycles++;
         quiet = tx_tvalid ? 0 : quiet + 1;
      end
      if (exp_data.size() != 0 || quiet < 8) begin
         errors++;
         $display("timeout after %0d cycles, %0d expected beats never arrived",
                  cycles, exp_data.size());
         exp_data.delete();
         exp_keep.delete();
         exp_last.delete();
         exp_info.delete();
      end
   endtask

   task automatic begin_test(input string name);
      tests++;
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      if (errors == test_start_errors) begin
         $display("test %0d %s: pass", tests, test_name);
      end else begin
         tests_failed++;
         $display("test %0d %s: FAIL with %0d errors", tests, test_name,
                  errors - test_start_errors);
      end
   endtask

   // ********************************************************************
   // test sequence
   // ********************************************************************
   initial begin
      logic [31:0] r;
      int          len;
      int          n;
      reset        = 1'b1;
      cfg_mac      = my_mac;
      cfg_ip       = my_ip;
      rx_tdata     = '0;
      rx_tkeep     = '0;
      rx_tvalid    = 1'b0;
      rx_tlast     = 1'b0;
      rx_tuser     = 1'b0;
      random_ready = 1'b0;
      ready_rng    = 32'habe0d6c6 ^ 32'h9e3779b9;    // separate stream for tready
      repeat (5) @(posedge clk);
      #10;
      reset = 1'b0;

      begin_test("payload lengths 1 to 16");
      for (len = 1; len <= 16; len++)
         offer_frame(good, len);
      wait_idle(2000);
      end_test();

      begin_test("wrong destination mac");
      offer_frame(bad_mac, 20);
      offer_frame(good, 21);
      wait_idle(500);
      end_test();

      begin_test("wrong ip and corrupted checksum");
      offer_frame(bad_ip, 9);
      offer_frame(bad_csum, 30);
      offer_frame(good, 5);
      wait_idle(500);
      end_test();

      begin_test("tuser on last beat");
      offer_frame(bad_user, 8);                    // aligned last beat with no carry
      offer_frame(bad_user, 6);                    // last beat followed by a carry beat
      offer_frame(good, 13);
      wait_idle(500);
      end_test();

      begin_test("random frames with random tready");
      random_ready = 1'b1;
      for (n = 0; n < 30; n++) begin
         r = rand32();
         offer_frame((r[2:0] >= 3'd4) ? good : int'(r[1:0]) + 1, int'(r[13:8]) + 1);
         repeat (int'(r[17:16])) next_cycle();    // idle gap of 0 to 3 cycles
      end
      wait_idle(10000);
      random_ready = 1'b0;
      end_test();

      $display("tests %0d, passed %0d, failed %0d, checks %0d, errors %0d",
               tests, tests - tests_failed, tests_failed, checks, errors);
      if (errors == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+hdl
+incdir+test
hdl/net_hdr_pkg.sv
hdl/stream_pkg.sv
hdl/ip_checksum.sv
hdl/header_parser.sv
hdl/payload_aligner.sv
hdl/frame_fifo.sv
hdl/fwft_fifo.sv
hdl/udp_rx_top.sv
test/tb_udp_rx.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = tb_udp_rx
FILELIST = project.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Simulation completed successfully

BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) $(wildcard hdl/*.svh test/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
